/* hdl/conv1_fetch.sv */
`timescale 1ns/100ps
`default_nettype none

module conv1_fetch #(
    parameter int MAP_W = 20,
    parameter int MAP_H = 16
) (
    input  wire logic                                    clk,
    input  wire logic                                    rst_n,
    input  wire logic                                    enable,
    input  wire logic [3:0]                              kernel_sel,
    input  wire conv_pkg::block_t                        rdata_0,
    input  wire conv_pkg::block_t                        rdata_1,
    input  wire conv_pkg::block_t                        rdata_2,
    input  wire conv_pkg::block_t                        rdata_3,
    input  wire logic [conv_pkg::CH_NUM*conv_pkg::CH_NUM*conv_pkg::WEIGHT_BITS-1:0] rdata_weight,
    input  wire logic [conv_pkg::BIAS_BITS-1:0]          rdata_bias,
    output conv_pkg::act_addr_t                          raddr_act,
    output conv_pkg::weight_addr_t                       raddr_weight,
    output conv_pkg::bias_addr_t                         raddr_bias,
    feature_if.src                                       feat_o
);

    conv_pkg::fetch_state_e state;
    logic [1:0] bias_cnt;
    conv_pkg::coord_t scan_x;
    conv_pkg::coord_t scan_y;

    logic addr_valid;
    conv_pkg::coord_t addr_x;
    conv_pkg::coord_t addr_y;
    logic data_valid;
    conv_pkg::coord_t data_x;
    conv_pkg::coord_t data_y;

    logic bias_ret_valid;
    logic [1:0] bias_ret_idx;

    conv_pkg::block_t bank_word [4];

    assign bank_word[0] = rdata_0;
    assign bank_word[1] = rdata_1;
    assign bank_word[2] = rdata_2;
    assign bank_word[3] = rdata_3;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= conv_pkg::IDLE;
            bias_cnt <= '0;
            scan_x <= '0;
            scan_y <= '0;
            addr_valid <= 1'b0;
            data_valid <= 1'b0;
            feat_o.feat_valid <= 1'b0;
            bias_ret_valid <= 1'b0;
            bias_ret_idx <= '0;
            raddr_act <= '0;
            raddr_weight <= '0;
            raddr_bias <= '0;
        end else begin
            addr_valid <= 1'b0;
            data_valid <= addr_valid;
            feat_o.feat_valid <= data_valid;
            bias_ret_valid <= (state == conv_pkg::LOAD_BIAS);
            bias_ret_idx <= bias_cnt;
            case (state)
                conv_pkg::IDLE: begin
                    if (enable) begin
                        state <= conv_pkg::LOAD_BIAS;
                        bias_cnt <= '0;
                        scan_x <= '0;
                        scan_y <= '0;
                        raddr_weight <= conv_pkg::weight_addr_t'(kernel_sel);
                        raddr_bias <= conv_pkg::bias_addr_t'(kernel_sel)
                                      * conv_pkg::bias_addr_t'(conv_pkg::CH_NUM);
                    end
                end
                conv_pkg::LOAD_BIAS: begin
                    if (bias_cnt == 2'(conv_pkg::CH_NUM - 1)) begin
                        state <= conv_pkg::SCAN;
                    end else begin
                        bias_cnt <= bias_cnt + 2'd1;
                        raddr_bias <= raddr_bias + 1'b1;
                    end
                end
                conv_pkg::SCAN: begin
                    raddr_act <= conv_pkg::block_addr(scan_x, scan_y);
                    addr_valid <= 1'b1;
                    if (scan_x == conv_pkg::coord_t'(MAP_W - 1)) begin
                        scan_x <= '0;
                        if (scan_y == conv_pkg::coord_t'(MAP_H - 1)) begin
                            state <= conv_pkg::DONE;
                        end else begin
                            scan_y <= scan_y + 1'b1;
                        end
                    end else begin
                        scan_x <= scan_x + 1'b1;
                    end
                end
                default: begin
                    state <= conv_pkg::DONE;
                end
            endcase
        end
    end

    // coordinates follow the read through the one-cycle SRAM latency
    always_ff @(posedge clk) begin
        addr_x <= scan_x;
        addr_y <= scan_y;
        data_x <= addr_x;
        data_y <= addr_y;
        feat_o.feat <= bank_word[conv_pkg::bank_sel(data_x, data_y)];
        feat_o.feat_x <= data_x;
        feat_o.feat_y <= data_y;
    end

    // the weight word returns together with the first bias word
    always_ff @(posedge clk) begin
        if (bias_ret_valid) begin
            feat_o.bias[bias_ret_idx] <= rdata_bias;
            if (bias_ret_idx == 2'd0) begin
                feat_o.weights <= rdata_weight;
            end
        end
    end

    read_addr_in_map: assert property (
        @(posedge clk) disable iff (!rst_n)
        addr_valid |-> raddr_act < conv_pkg::ROW_WORDS * MAP_H / 2
    ) else $error("block read address beyond the feature map");

endmodule

`default_nettype wire

/* hdl/conv1_top.sv */
`timescale 1ns/100ps
`default_nettype none

module conv1_top #(
    parameter int MAP_W = 20,
    parameter int MAP_H = 16
) (
    input  wire logic                                    clk,
    input  wire logic                                    rst_n,
    input  wire logic                                    enable,
    input  wire logic [3:0]                              kernel_sel,
    input  wire conv_pkg::block_t                        sram_rdata_0,
    input  wire conv_pkg::block_t                        sram_rdata_1,
    input  wire conv_pkg::block_t                        sram_rdata_2,
    input  wire conv_pkg::block_t                        sram_rdata_3,
    input  wire logic [conv_pkg::CH_NUM*conv_pkg::CH_NUM*conv_pkg::WEIGHT_BITS-1:0] sram_rdata_weight,
    input  wire logic [conv_pkg::BIAS_BITS-1:0]          sram_rdata_bias,
    output conv_pkg::act_addr_t                          sram_raddr_act,
    output conv_pkg::weight_addr_t                       sram_raddr_weight,
    output conv_pkg::bias_addr_t                         sram_raddr_bias,
    output logic                                         sram_wen_0,
    output logic                                         sram_wen_1,
    output logic                                         sram_wen_2,
    output logic                                         sram_wen_3,
    output conv_pkg::act_addr_t                          sram_waddr,
    output conv_pkg::block_t                             sram_wdata,
    output logic                                         valid
);

    feature_if feat_bus ();
    result_if  res_bus ();

    conv1_fetch #(
        .MAP_W (MAP_W),
        .MAP_H (MAP_H)
    ) fetch_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .enable       (enable),
        .kernel_sel   (kernel_sel),
        .rdata_0      (sram_rdata_0),
        .rdata_1      (sram_rdata_1),
        .rdata_2      (sram_rdata_2),
        .rdata_3      (sram_rdata_3),
        .rdata_weight (sram_rdata_weight),
        .rdata_bias   (sram_rdata_bias),
        .raddr_act    (sram_raddr_act),
        .raddr_weight (sram_raddr_weight),
        .raddr_bias   (sram_raddr_bias),
        .feat_o       (feat_bus.src)
    );

    pointwise_mac mac_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .feat_i (feat_bus.dst),
        .res_o  (res_bus.src)
    );

    result_writer #(
        .MAP_W (MAP_W),
        .MAP_H (MAP_H)
    ) writer_i (
        .clk   (clk),
        .rst_n (rst_n),
        .res_i (res_bus.dst),
        .wen_0 (sram_wen_0),
        .wen_1 (sram_wen_1),
        .wen_2 (sram_wen_2),
        .wen_3 (sram_wen_3),
        .waddr (sram_waddr),
        .wdata (sram_wdata),
        .valid (valid)
    );

endmodule

`default_nettype wire

/* hdl/conv_pkg.sv */
`default_nettype none

package conv_pkg;

    localparam int CH_NUM = 3;
    localparam int PIX_PER_BLOCK = 9;
    localparam int ACT_BITS = 10;
    localparam int WEIGHT_BITS = 10;
    localparam int BIAS_BITS = 10;
    localparam int PROD_BITS = 20;
    localparam int SUM_BITS = 26;
    localparam int FRAC_BITS = 8;
    localparam int ROUND_CONST = 128;
    localparam int ROW_WORDS = 10;
    localparam int ACT_ADDR_BITS = 9;
    localparam int WEIGHT_ADDR_BITS = 7;
    localparam int BIAS_ADDR_BITS = 5;

    typedef logic signed [ACT_BITS-1:0] act_t;
    typedef logic signed [WEIGHT_BITS-1:0] weight_t;
    typedef logic signed [SUM_BITS-1:0] sum_t;
    // slot c*9+p holds channel c, pixel p
    typedef logic [CH_NUM*PIX_PER_BLOCK*ACT_BITS-1:0] block_t;
    typedef logic [6:0] coord_t;
    typedef logic [ACT_ADDR_BITS-1:0] act_addr_t;
    typedef logic [WEIGHT_ADDR_BITS-1:0] weight_addr_t;
    typedef logic [BIAS_ADDR_BITS-1:0] bias_addr_t;

    typedef enum logic [1:0] {IDLE, LOAD_BIAS, SCAN, DONE} fetch_state_e;

    // each bank holds one block out of every 2x2 group
    function automatic act_addr_t block_addr(input coord_t x, input coord_t y);
        return act_addr_t'(x >> 1) + act_addr_t'(y >> 1) * act_addr_t'(ROW_WORDS);
    endfunction

    function automatic logic [1:0] bank_sel(input coord_t x, input coord_t y);
        return {y[0], x[0]};
    endfunction

endpackage

`default_nettype wire

/* hdl/feature_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface feature_if;

    logic feat_valid;
    conv_pkg::block_t feat;
    conv_pkg::coord_t feat_x;
    conv_pkg::coord_t feat_y;
    // weight o*3+c scales input channel c into output channel o
    conv_pkg::weight_t [conv_pkg::CH_NUM*conv_pkg::CH_NUM-1:0] weights;
    conv_pkg::act_t [conv_pkg::CH_NUM-1:0] bias;

    modport src (
        output feat_valid, feat, feat_x, feat_y, weights, bias
    );

    modport dst (
        input feat_valid, feat, feat_x, feat_y, weights, bias
    );

endinterface

`default_nettype wire

/* hdl/pointwise_mac.sv */
`timescale 1ns/100ps
`default_nettype none

module pointwise_mac (
    input  wire logic clk,
    input  wire logic rst_n,
    feature_if.dst    feat_i,
    result_if.src     res_o
);

    localparam int CH = conv_pkg::CH_NUM;
    localparam int PIX = conv_pkg::PIX_PER_BLOCK;
    localparam int ACT_W = conv_pkg::ACT_BITS;

    // product (o*9+p)*3+c is channel c of pixel p scaled into output o
    logic signed [conv_pkg::PROD_BITS-1:0] prod [CH*PIX*CH];
    conv_pkg::sum_t bias_sh [CH];
    logic prod_valid;
    conv_pkg::coord_t prod_x;
    conv_pkg::coord_t prod_y;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prod_valid <= 1'b0;
            res_o.res_valid <= 1'b0;
        end else begin
            prod_valid <= feat_i.feat_valid;
            res_o.res_valid <= prod_valid;
        end
    end

    always_ff @(posedge clk) begin
        for (int o = 0; o < CH; o++) begin
            for (int p = 0; p < PIX; p++) begin
                for (int c = 0; c < CH; c++) begin
                    prod[(o*PIX+p)*CH+c] <=
                        $signed(feat_i.feat[(c*PIX+p)*ACT_W +: ACT_W])
                        * $signed(feat_i.weights[o*CH+c]);
                end
            end
            bias_sh[o] <= conv_pkg::sum_t'($signed(feat_i.bias[o])) <<< conv_pkg::FRAC_BITS;
        end
        prod_x <= feat_i.feat_x;
        prod_y <= feat_i.feat_y;
    end

    always_ff @(posedge clk) begin
        for (int o = 0; o < CH; o++) begin
            for (int p = 0; p < PIX; p++) begin
                res_o.sums[o*PIX+p] <= prod[(o*PIX+p)*CH]
                                       + prod[(o*PIX+p)*CH+1]
                                       + prod[(o*PIX+p)*CH+2]
                                       + bias_sh[o];
            end
        end
        res_o.res_x <= prod_x;
        res_o.res_y <= prod_y;
    end

endmodule

`default_nettype wire

/* hdl/result_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface result_if;

    logic res_valid;
    // slot o*9+p holds output channel o, pixel p
    conv_pkg::sum_t [conv_pkg::CH_NUM*conv_pkg::PIX_PER_BLOCK-1:0] sums;
    conv_pkg::coord_t res_x;
    conv_pkg::coord_t res_y;

    modport src (
        output res_valid, sums, res_x, res_y
    );

    modport dst (
        input res_valid, sums, res_x, res_y
    );

endinterface

`default_nettype wire

/* hdl/result_writer.sv */
`timescale 1ns/100ps
`default_nettype none

module result_writer #(
    parameter int MAP_W = 20,
    parameter int MAP_H = 16
) (
    input  wire logic           clk,
    input  wire logic           rst_n,
    result_if.dst               res_i,
    output logic                wen_0,
    output logic                wen_1,
    output logic                wen_2,
    output logic                wen_3,
    output conv_pkg::act_addr_t waddr,
    output conv_pkg::block_t    wdata,
    output logic                valid
);

    localparam int SLOTS = conv_pkg::CH_NUM * conv_pkg::PIX_PER_BLOCK;
    localparam int ACT_W = conv_pkg::ACT_BITS;

    conv_pkg::sum_t rounded [SLOTS];
    conv_pkg::block_t wdata_n;
    logic [3:0] wen_n;
    logic [3:0] wen_q;
    logic last_wr;

    // round half up, then keep the bits just above the fraction
    always_comb begin
        for (int i = 0; i < SLOTS; i++) begin
            rounded[i] = res_i.sums[i] + conv_pkg::sum_t'(conv_pkg::ROUND_CONST);
            wdata_n[i*ACT_W +: ACT_W] = rounded[i][conv_pkg::FRAC_BITS +: ACT_W];
        end
    end

    always_comb begin
        wen_n = 4'b1111;
        if (res_i.res_valid) begin
            wen_n[conv_pkg::bank_sel(res_i.res_x, res_i.res_y)] = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wen_q <= 4'b1111;
            last_wr <= 1'b0;
            valid <= 1'b0;
        end else begin
            wen_q <= wen_n;
            last_wr <= res_i.res_valid
                       && res_i.res_x == conv_pkg::coord_t'(MAP_W - 1)
                       && res_i.res_y == conv_pkg::coord_t'(MAP_H - 1);
            // sticky until the next reset
            valid <= valid | last_wr;
        end
    end

    always_ff @(posedge clk) begin
        waddr <= conv_pkg::block_addr(res_i.res_x, res_i.res_y);
        wdata <= wdata_n;
    end

    assign wen_0 = wen_q[0];
    assign wen_1 = wen_q[1];
    assign wen_2 = wen_q[2];
    assign wen_3 = wen_q[3];

    // once the last block is written the upstream stages must stay quiet
    no_write_after_done: assert property (
        @(posedge clk) disable iff (!rst_n)
        valid |-> &wen_q
    ) else $error("bank written after the layer finished");

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build the conv1 testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module conv1_tb \
    -f sources.f --Mdir obj_dir -o conv1_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/conv1_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Test failures found" "$LOG"; then
    echo "simulation reported failures, see $LOG"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi
echo "simulation finished without failures"
exit 0

/* sources.f */
+incdir+verification
hdl/conv_pkg.sv
hdl/feature_if.sv
hdl/result_if.sv
hdl/conv1_fetch.sv
hdl/pointwise_mac.sv
hdl/result_writer.sv
hdl/conv1_top.sv
verification/conv1_tb.sv

/* verification/conv1_model.svh */
`ifndef CONV1_MODEL_SVH
`define CONV1_MODEL_SVH

// contents of the input banks, the weight SRAM and the bias SRAM
conv_pkg::block_t in_bank [4][512];
logic [89:0] weight_mem [128];
logic [9:0] bias_mem [32];
// what each output bank should hold once the layer is done
conv_pkg::block_t exp_bank [4][512];

logic [31:0] lcg_state = 32'hb343;

function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

function automatic logic [9:0] random_10();
    logic [31:0] r;
    r = next_random();
    return r[25:16];
endfunction

// one output channel of one pixel, rounded half up to 10 bits
function automatic logic [9:0] expected_pixel(input conv_pkg::block_t word,
                                              input logic [89:0] wword,
                                              input logic [9:0] b, input int o, input int p);
    int acc;
    int a;
    int w;
    acc = $signed(b);
    acc = acc * 256;
    for (int c = 0; c < 3; c++) begin
        a = $signed(word[(c*9+p)*10 +: 10]);
        w = $signed(wword[(o*3+c)*10 +: 10]);
        acc = acc + a * w;
    end
    acc = (acc + 128) >>> 8;
    return acc[9:0];
endfunction

task automatic fill_memories();
    conv_pkg::block_t word;
    logic [89:0] wword;
    for (int b = 0; b < 4; b++) begin
        for (int a = 0; a < 512; a++) begin
            for (int s = 0; s < 27; s++) begin
                word[s*10 +: 10] = random_10();
            end
            in_bank[b][a] = word;
        end
    end
    for (int a = 0; a < 128; a++) begin
        for (int s = 0; s < 9; s++) begin
            wword[s*10 +: 10] = random_10();
        end
        weight_mem[a] = wword;
    end
    for (int a = 0; a < 32; a++) begin
        bias_mem[a] = random_10();
    end
endtask

task automatic build_expected(input logic [3:0] ksel);
    int b;
    int addr;
    conv_pkg::block_t word;
    for (int y = 0; y < MAP_H; y++) begin
        for (int x = 0; x < MAP_W; x++) begin
            b = (y % 2) * 2 + x % 2;
            addr = x / 2 + (y / 2) * ROW_WORDS;
            for (int o = 0; o < 3; o++) begin
                for (int p = 0; p < 9; p++) begin
                    word[(o*9+p)*10 +: 10] = expected_pixel(in_bank[b][addr],
                        weight_mem[ksel], bias_mem[ksel*3+o], o, p);
                end
            end
            exp_bank[b][addr] = word;
        end
    end
endtask

`endif

/* verification/conv1_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module conv1_tb;

    localparam int MAP_W = 20;
    localparam int MAP_H = 16;
    localparam int ROW_WORDS = 10;
    localparam int BLOCKS = MAP_W * MAP_H;
    localparam int CLK_PERIOD = 8;
    localparam int RESET_CYCLES = 16;
    localparam int WRITE_LATENCY = 5;
    // two runs, each a full scan plus some slack, with a factor of two on top
    localparam int WATCHDOG_CYCLES = 2 * (2 * (BLOCKS + 20));

    logic clk;
    logic rst_n;
    logic enable;
    logic [3:0] kernel_sel;
    conv_pkg::block_t sram_rdata_0 = '0;
    conv_pkg::block_t sram_rdata_1 = '0;
    conv_pkg::block_t sram_rdata_2 = '0;
    conv_pkg::block_t sram_rdata_3 = '0;
    logic [89:0] sram_rdata_weight = '0;
    logic [9:0] sram_rdata_bias = '0;
    logic [8:0] sram_raddr_act;
    logic [6:0] sram_raddr_weight;
    logic [4:0] sram_raddr_bias;
    logic sram_wen_0;
    logic sram_wen_1;
    logic sram_wen_2;
    logic sram_wen_3;
    logic [8:0] sram_waddr;
    conv_pkg::block_t sram_wdata;
    logic valid;
    logic [3:0] wen_bus;

    conv_pkg::block_t out_bank_0 [512];
    conv_pkg::block_t out_bank_1 [512];
    conv_pkg::block_t out_bank_2 [512];
    conv_pkg::block_t out_bank_3 [512];

    int write_count;
    logic valid_seen;
    logic [8:0] raddr_hist [$];

    `include "conv1_model.svh"

    conv1_top #(
        .MAP_W (MAP_W),
        .MAP_H (MAP_H)
    ) dut_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .enable            (enable),
        .kernel_sel        (kernel_sel),
        .sram_rdata_0      (sram_rdata_0),
        .sram_rdata_1      (sram_rdata_1),
        .sram_rdata_2      (sram_rdata_2),
        .sram_rdata_3      (sram_rdata_3),
        .sram_rdata_weight (sram_rdata_weight),
        .sram_rdata_bias   (sram_rdata_bias),
        .sram_raddr_act    (sram_raddr_act),
        .sram_raddr_weight (sram_raddr_weight),
        .sram_raddr_bias   (sram_raddr_bias),
        .sram_wen_0        (sram_wen_0),
        .sram_wen_1        (sram_wen_1),
        .sram_wen_2        (sram_wen_2),
        .sram_wen_3        (sram_wen_3),
        .sram_waddr        (sram_waddr),
        .sram_wdata        (sram_wdata),
        .valid             (valid)
    );

    assign wen_bus = {sram_wen_3, sram_wen_2, sram_wen_1, sram_wen_0};

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // SRAMs with one cycle of read latency
    always @(posedge clk) begin
        sram_rdata_0 <= in_bank[0][sram_raddr_act];
        sram_rdata_1 <= in_bank[1][sram_raddr_act];
        sram_rdata_2 <= in_bank[2][sram_raddr_act];
        sram_rdata_3 <= in_bank[3][sram_raddr_act];
        sram_rdata_weight <= weight_mem[sram_raddr_weight];
        sram_rdata_bias <= bias_mem[sram_raddr_bias];
        if (!sram_wen_0) out_bank_0[sram_waddr] <= sram_wdata;
        if (!sram_wen_1) out_bank_1[sram_waddr] <= sram_wdata;
        if (!sram_wen_2) out_bank_2[sram_waddr] <= sram_wdata;
        if (!sram_wen_3) out_bank_3[sram_waddr] <= sram_wdata;
    end

    task automatic stop_with_failure();
        $display("Test failures found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [269:0] expected,
                               input logic [269:0] actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    function automatic conv_pkg::block_t read_out_bank(input int b, input int addr);
        case (b)
            0: return out_bank_0[addr];
            1: return out_bank_1[addr];
            2: return out_bank_2[addr];
            default: return out_bank_3[addr];
        endcase
    endfunction

    task automatic clear_output_banks();
        for (int a = 0; a < 512; a++) begin
            out_bank_0[a] = 'x;
            out_bank_1[a] = 'x;
            out_bank_2[a] = 'x;
            out_bank_3[a] = 'x;
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        enable <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    task automatic compare_banks(input int run);
        int b;
        int addr;
        for (int y = 0; y < MAP_H; y++) begin
            for (int x = 0; x < MAP_W; x++) begin
                b = (y % 2) * 2 + x % 2;
                addr = x / 2 + (y / 2) * ROW_WORDS;
                check_value($sformatf("run%0d_block_x%0d_y%0d", run, x, y),
                            exp_bank[b][addr], read_out_bank(b, addr));
            end
        end
    endtask

    task automatic run_layer(input int run, input logic [3:0] ksel);
        fill_memories();
        clear_output_banks();
        build_expected(ksel);
        apply_reset();
        repeat (2) @(negedge clk);
        check_value($sformatf("run%0d_idle_wen", run), 4'b1111, wen_bus);
        check_value($sformatf("run%0d_idle_valid", run), 1'b0, valid);
        @(posedge clk);
        enable <= 1'b1;
        kernel_sel <= ksel;
        @(posedge clk);
        enable <= 1'b0;
        // kernel_sel only counts on the enable cycle
        kernel_sel <= ~ksel;
        // the weight word and the three bias words are requested right after enable
        for (int i = 0; i < 3; i++) begin
            @(negedge clk);
            check_value($sformatf("run%0d_raddr_weight", run), ksel, sram_raddr_weight);
            check_value($sformatf("run%0d_raddr_bias_%0d", run, i),
                        ksel * 3 + i, sram_raddr_bias);
        end
        while (valid !== 1'b1) @(negedge clk);
        check_value($sformatf("run%0d_block_writes", run), BLOCKS, write_count);
        compare_banks(run);
        repeat (20) @(negedge clk);
    endtask

    // write enables, write order and read-to-write distance, seen at the falling edge
    always @(negedge clk) begin
        int low_count;
        int bank;
        int exp_x;
        int exp_y;
        if (!rst_n) begin
            write_count = 0;
            valid_seen = 1'b0;
            raddr_hist.delete();
        end else begin
            raddr_hist.push_back(sram_raddr_act);
            if (raddr_hist.size() > WRITE_LATENCY + 1) begin
                raddr_hist.pop_front();
            end
            low_count = 0;
            bank = 0;
            for (int i = 0; i < 4; i++) begin
                if (wen_bus[i] !== 1'b1) begin
                    low_count++;
                    bank = i;
                end
            end
            check_value("one_write_enable_low", 1'b1, low_count <= 1);
            if (low_count == 1) begin
                if (write_count >= BLOCKS) begin
                    $display("Error: a bank write came after the last block of the scan");
                    stop_with_failure();
                end
                exp_x = write_count % MAP_W;
                exp_y = write_count / MAP_W;
                check_value("write_bank", (exp_y % 2) * 2 + exp_x % 2, bank);
                check_value("write_addr", exp_x / 2 + (exp_y / 2) * ROW_WORDS, sram_waddr);
                check_value("read_to_write_latency", raddr_hist[0], sram_waddr);
                write_count++;
            end
            if (valid_seen) begin
                check_value("valid_sticky", 1'b1, valid);
            end
            if (valid === 1'b1) begin
                valid_seen = 1'b1;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Error: valid never rose within %0d cycles", WATCHDOG_CYCLES);
        stop_with_failure();
    end

    initial begin
        logic [31:0] r;
        logic [3:0] k1;
        logic [3:0] k2;
        rst_n = 1'b0;
        enable = 1'b0;
        kernel_sel = 4'd0;
        // selects stay below 10 so that all three bias words fit the bias SRAM
        r = next_random();
        k1 = 4'(r % 10);
        r = next_random();
        k2 = 4'((k1 + 1 + r % 9) % 10);
        run_layer(1, k1);
        run_layer(2, k2);
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire
